/* flist.f */
design/decode_pkg.sv
design/operand_decode.sv
design/imm_gen.sv
design/unit_router.sv
design/hazard_gate.sv
design/dec_out_reg.sv
design/inst_decoder.sv
sim/tb_inst_decoder.sv

/* sim/tb_inst_decoder.sv */
// table-driven testbench for the decode stage that runs as the simulation top from the flist
`default_nettype none

module tb_inst_decoder;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TESTS        = 18;
    localparam int TIMEOUT_CYCLES = 20 * N_TESTS + 50;

    // one-hot unit code in the order {alu, lsu, mext, csr, spu, custom, err}
    localparam logic [6:0] U_ALU    = 7'b1000000;
    localparam logic [6:0] U_LSU    = 7'b0100000;
    localparam logic [6:0] U_MEXT   = 7'b0010000;
    localparam logic [6:0] U_CSR    = 7'b0001000;
    localparam logic [6:0] U_SPU    = 7'b0000100;
    localparam logic [6:0] U_CUSTOM = 7'b0000010;
    localparam logic [6:0] U_ERR    = 7'b0000001;

    logic                  clk;
    logic                  rst_n;
    logic                  fetched_inst_vld;
    logic                  fetched_inst_rdy;
    decode_pkg::inst_t     fetched_inst_pld;
    decode_pkg::pc_t       fetched_inst_pc;
    decode_pkg::inst_id_t  fetched_inst_id;
    decode_pkg::reg_mask_t register_lock;
    logic                  dec_inst_vld;
    logic                  dec_inst_rdy;
    decode_pkg::inst_t     dec_inst_pld;
    decode_pkg::inst_id_t  dec_inst_id;
    decode_pkg::pc_t       dec_inst_pc;
    decode_pkg::reg_idx_t  dec_inst_rd;
    logic                  dec_inst_rd_en;
    decode_pkg::reg_idx_t  dec_inst_rs1;
    decode_pkg::reg_idx_t  dec_inst_rs2;
    decode_pkg::imm_t      dec_inst_imm;
    logic                  goto_lsu;
    logic                  goto_alu;
    logic                  goto_err;
    logic                  goto_mext;
    logic                  goto_csr;
    logic                  goto_custom;
    logic                  goto_spu;

    // stimulus table
    string                 t_name  [N_TESTS];
    decode_pkg::inst_t     t_inst  [N_TESTS];
    decode_pkg::reg_mask_t t_lock  [N_TESTS];
    int                    t_hold  [N_TESTS];
    int                    t_stall [N_TESTS];
    int                    n_tests = 0;

    // expected decode of the entry in flight
    string                 cur_name;
    decode_pkg::reg_idx_t  exp_rd;
    decode_pkg::reg_idx_t  exp_rs1;
    decode_pkg::reg_idx_t  exp_rs2;
    logic                  exp_rd_en;
    logic                  exp_rs1_en;
    logic                  exp_rs2_en;
    decode_pkg::imm_t      exp_imm;
    logic [6:0]            exp_unit;
    decode_pkg::inst_t     exp_pld;
    decode_pkg::pc_t       exp_pc;
    decode_pkg::inst_id_t  exp_id;

    integer                seed        = 32'hed98;
    int                    err_count   = 0;
    int                    fail_tests  = 0;
    int                    cycle_count = 0;

    inst_decoder u_dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetched_inst_vld (fetched_inst_vld),
        .fetched_inst_rdy (fetched_inst_rdy),
        .fetched_inst_pld (fetched_inst_pld),
        .fetched_inst_pc  (fetched_inst_pc),
        .fetched_inst_id  (fetched_inst_id),
        .register_lock    (register_lock),
        .dec_inst_vld     (dec_inst_vld),
        .dec_inst_rdy     (dec_inst_rdy),
        .dec_inst_pld     (dec_inst_pld),
        .dec_inst_id      (dec_inst_id),
        .dec_inst_pc      (dec_inst_pc),
        .dec_inst_rd      (dec_inst_rd),
        .dec_inst_rd_en   (dec_inst_rd_en),
        .dec_inst_rs1     (dec_inst_rs1),
        .dec_inst_rs2     (dec_inst_rs2),
        .dec_inst_imm     (dec_inst_imm),
        .goto_lsu         (goto_lsu),
        .goto_alu         (goto_alu),
        .goto_err         (goto_err),
        .goto_mext        (goto_mext),
        .goto_csr         (goto_csr),
        .goto_custom      (goto_custom),
        .goto_spu         (goto_spu)
    );

    always begin
        clk = 1'b0;
        #50;
        clk = 1'b1;
        #50;
    end

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ========================================================================
    // table, reference decode and compare helpers
    // ========================================================================

    task automatic add_test(input string name, input decode_pkg::inst_t inst,
                            input decode_pkg::reg_mask_t lock, input int hold,
                            input int stall);
        t_name[n_tests]  = name;
        t_inst[n_tests]  = inst;
        t_lock[n_tests]  = lock;
        t_hold[n_tests]  = hold;
        t_stall[n_tests] = stall;
        n_tests++;
    endtask

    task automatic build_table();
        // name, word, lock mask, lock hold cycles, consumer stall cycles
        add_test("lui",          32'h123452B7, 32'h0000_0000, 0, 5);
        add_test("auipc",        32'hFFFFF397, 32'h0000_0000, 0, 0);
        add_test("jal",          32'hFF5FF0EF, 32'h0000_0000, 0, 1);
        add_test("jalr",         32'h00808067, 32'h0001_0000, 0, 0);
        add_test("beq_lock_rs2", 32'hFE208CE3, 32'h0000_0004, 3, 0);
        add_test("lw",           32'hFFC12503, 32'h0000_0000, 0, 2);
        add_test("sw_lock_rs2",  32'h00A12823, 32'h0001_0400, 1, 0);
        add_test("addi_rs2_free", 32'hFFF20193, 32'h8000_0000, 4, 0);
        add_test("add",          32'h005201B3, 32'h0000_0000, 0, 3);
        add_test("mul",          32'h02838333, 32'h0000_0000, 0, 0);
        add_test("amoadd",       32'h00A5A4AF, 32'h0000_0000, 0, 1);
        add_test("ecall",        32'h00000073, 32'h0000_0000, 0, 0);
        add_test("csrrw_lock",   32'h300312F3, 32'h0000_0040, 2, 0);
        add_test("custom0",      32'h0000500B, 32'h0000_0000, 0, 0);
        add_test("custom3",      32'h1234507B, 32'h0000_0000, 0, 2);
        add_test("unknown_opc",  32'h00000057, 32'hFFFF_FFFF, 2, 0);
        add_test("compressed",   32'h00004501, 32'hFFFF_FFFF, 3, 1);
        add_test("fence",        32'h0FF0000F, 32'h0000_0000, 0, 1);
    endtask

    task automatic ref_decode(input decode_pkg::inst_t inst);
        decode_pkg::opcode_t opc;
        decode_pkg::funct3_t f3;
        logic                rv32;
        opc  = inst[6:2];
        f3   = inst[14:12];
        rv32 = (inst[1:0] == 2'b11);
        exp_rd     = inst[11:7];
        exp_rs1    = inst[19:15];
        exp_rs2    = inst[24:20];
        exp_rd_en  = 1'b1;
        exp_rs1_en = 1'b1;
        exp_rs2_en = 1'b1;
        if (opc == decode_pkg::OPC_BRANCH || opc == decode_pkg::OPC_STORE)
            exp_rd_en = 1'b0;
        if (opc == decode_pkg::OPC_SYSTEM && f3 == decode_pkg::F3_PRIV)
            exp_rd_en = 1'b0;
        if (opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_AUIPC ||
            opc == decode_pkg::OPC_JAL) begin
            exp_rs1_en = 1'b0;
            exp_rs2_en = 1'b0;
        end
        if (opc == decode_pkg::OPC_JALR || opc == decode_pkg::OPC_LOAD ||
            opc == decode_pkg::OPC_OP_IMM || opc == decode_pkg::OPC_SYSTEM)
            exp_rs2_en = 1'b0;
        if (!rv32) begin
            exp_rd_en  = 1'b0;
            exp_rs1_en = 1'b0;
            exp_rs2_en = 1'b0;
        end
        // immediate by format
        if (opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_AUIPC)
            exp_imm = {inst[31:12], 12'h000};
        else if (opc == decode_pkg::OPC_JAL)
            exp_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        else if (opc == decode_pkg::OPC_BRANCH)
            exp_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        else if (opc == decode_pkg::OPC_STORE)
            exp_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        else if (opc == decode_pkg::OPC_AMO)
            exp_imm = 32'h0;
        else
            exp_imm = {{20{inst[31]}}, inst[31:20]};
        // execution unit
        if (!rv32)
            exp_unit = U_ERR;
        else if (opc == decode_pkg::OPC_LUI || opc == decode_pkg::OPC_AUIPC ||
                 opc == decode_pkg::OPC_JAL || opc == decode_pkg::OPC_JALR ||
                 opc == decode_pkg::OPC_OP_IMM || opc == decode_pkg::OPC_BRANCH ||
                 opc == decode_pkg::OPC_MISC_MEM)
            exp_unit = U_ALU;
        else if (opc == decode_pkg::OPC_OP)
            exp_unit = inst[25] ? U_MEXT : U_ALU;
        else if (opc == decode_pkg::OPC_LOAD || opc == decode_pkg::OPC_STORE ||
                 opc == decode_pkg::OPC_AMO)
            exp_unit = U_LSU;
        else if (opc == decode_pkg::OPC_SYSTEM)
            exp_unit = (f3 == decode_pkg::F3_PRIV) ? U_SPU : U_CSR;
        else if (opc == decode_pkg::OPC_CUST0 || opc == decode_pkg::OPC_CUST1 ||
                 opc == decode_pkg::OPC_CUST2 || opc == decode_pkg::OPC_CUST3)
            exp_unit = U_CUSTOM;
        else
            exp_unit = U_ERR;
    endtask

    task automatic check_field(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %0s %0s: expected %h, actual %h", cur_name, field, exp, act);
            err_count++;
        end
    endtask

    task automatic check_idle(input string phase);
        if (dec_inst_vld !== 1'b0 || {goto_alu, goto_lsu, goto_mext, goto_csr,
                                      goto_spu, goto_custom, goto_err} !== 7'b0) begin
            $display("%0s: output valid or a unit select is high with nothing accepted",
                     phase);
            err_count++;
        end
    endtask

    task automatic check_outputs();
        logic [6:0] act_unit;
        act_unit = {goto_alu, goto_lsu, goto_mext, goto_csr, goto_spu, goto_custom, goto_err};
        if (dec_inst_vld !== 1'b1) begin
            $display("%0s: dec_inst_vld is low while the instruction should be held",
                     cur_name);
            err_count++;
        end
        if ($countones(act_unit) != 1) begin
            $display("%0s: not exactly one unit select is high (%b)", cur_name, act_unit);
            err_count++;
        end
        check_field("pld",   exp_pld,   dec_inst_pld);
        check_field("pc",    exp_pc,    dec_inst_pc);
        check_field("id",    exp_id,    dec_inst_id);
        check_field("rd",    exp_rd,    dec_inst_rd);
        check_field("rs1",   exp_rs1,   dec_inst_rs1);
        check_field("rs2",   exp_rs2,   dec_inst_rs2);
        check_field("rd_en", exp_rd_en, dec_inst_rd_en);
        check_field("imm",   exp_imm,   dec_inst_imm);
        check_field("unit",  exp_unit,  act_unit);
    endtask

    // ========================================================================
    // one table entry from offer through lock wait, check, stall and drain
    // ========================================================================

    task automatic run_test(input int i);
        int     waited;
        int     exp_wait;
        int     errs_before;
        integer rnd;
        logic   locked;
        cur_name = t_name[i];
        exp_pld  = t_inst[i];
        ref_decode(t_inst[i]);
        locked = (exp_rd_en  && t_lock[i][exp_rd])  ||
                 (exp_rs1_en && t_lock[i][exp_rs1]) ||
                 (exp_rs2_en && t_lock[i][exp_rs2]);
        exp_wait    = locked ? t_hold[i] : 0;
        exp_pc      = $random(seed);
        rnd         = $random(seed);
        exp_id      = rnd[3:0];
        errs_before = err_count;
        waited      = 0;

        @(posedge clk);
        fetched_inst_vld <= 1'b1;
        fetched_inst_pld <= t_inst[i];
        fetched_inst_pc  <= exp_pc;
        fetched_inst_id  <= exp_id;
        register_lock    <= t_lock[i];
        @(negedge clk);
        while (!fetched_inst_rdy) begin
            // nothing may reach the output register while locked
            if (dec_inst_vld !== 1'b0) begin
                $display("%0s: output became valid while the fetch side was stalled",
                         cur_name);
                err_count++;
            end
            waited++;
            @(posedge clk);
            if (waited == t_hold[i]) begin
                register_lock <= '0;
            end
            @(negedge clk);
        end
        if (waited != exp_wait) begin
            $display("ERROR %0s stall cycles: expected %0d, actual %0d",
                     cur_name, exp_wait, waited);
            err_count++;
        end

        // transfer on this edge and scramble the inputs behind it
        @(posedge clk);
        fetched_inst_vld <= 1'b0;
        fetched_inst_pld <= $random(seed);
        register_lock    <= '0;
        @(negedge clk);
        check_outputs();

        repeat (t_stall[i]) begin
            @(posedge clk);
            @(negedge clk);
            check_outputs();
            if (fetched_inst_rdy !== 1'b0) begin
                $display("%0s: fetched_inst_rdy is high while the output is stalled",
                         cur_name);
                err_count++;
            end
        end

        @(posedge clk);
        dec_inst_rdy <= 1'b1;
        @(posedge clk);
        dec_inst_rdy <= 1'b0;
        @(negedge clk);
        if (dec_inst_vld !== 1'b0) begin
            $display("%0s: output still valid after it was taken once", cur_name);
            err_count++;
        end

        if (err_count == errs_before) begin
            $display("test %0s: ok", cur_name);
        end else begin
            $display("test %0s: failed", cur_name);
            fail_tests++;
        end
    endtask

    initial begin
        rst_n            = 1'b0;
        fetched_inst_vld = 1'b0;
        fetched_inst_pld = '0;
        fetched_inst_pc  = '0;
        fetched_inst_id  = '0;
        register_lock    = '0;
        dec_inst_rdy     = 1'b0;
        build_table();

        // reset spans two rising edges
        @(posedge clk);
        @(negedge clk);
        check_idle("reset");
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("idle after reset");
        end

        for (int i = 0; i < n_tests; i++) begin
            run_test(i);
        end

        $display("tests %0d, failed %0d, errors %0d", n_tests, fail_tests, err_count);
        if (err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/inst_decoder.sv */
// decode stage top, connects the field decoders, the lock gate and the output register
`default_nettype none

module inst_decoder (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  fetched_inst_vld,
    output logic                  fetched_inst_rdy,
    input  decode_pkg::inst_t     fetched_inst_pld,
    input  decode_pkg::pc_t       fetched_inst_pc,
    input  decode_pkg::inst_id_t  fetched_inst_id,

    input  decode_pkg::reg_mask_t register_lock,

    output logic                  dec_inst_vld,
    input  logic                  dec_inst_rdy,
    output decode_pkg::inst_t     dec_inst_pld,
    output decode_pkg::inst_id_t  dec_inst_id,
    output decode_pkg::pc_t       dec_inst_pc,
    output decode_pkg::reg_idx_t  dec_inst_rd,
    output logic                  dec_inst_rd_en,
    output decode_pkg::reg_idx_t  dec_inst_rs1,
    output decode_pkg::reg_idx_t  dec_inst_rs2,
    output decode_pkg::imm_t      dec_inst_imm,

    output logic                  goto_lsu,
    output logic                  goto_alu,
    output logic                  goto_err,
    output logic                  goto_mext,
    output logic                  goto_csr,
    output logic                  goto_custom,
    output logic                  goto_spu
);

    decode_pkg::reg_idx_t rd;
    decode_pkg::reg_idx_t rs1;
    decode_pkg::reg_idx_t rs2;
    logic                 rd_en;
    logic                 rs1_en;
    logic                 rs2_en;
    decode_pkg::imm_t     imm;
    logic                 sel_alu;
    logic                 sel_lsu;
    logic                 sel_mext;
    logic                 sel_csr;
    logic                 sel_spu;
    logic                 sel_custom;
    logic                 sel_err;
    logic                 gated_vld;
    logic                 reg_rdy;

    // ========================================================================
    // combinational decode of the fetched word
    // ========================================================================

    operand_decode u_operand_decode (
        .inst   (fetched_inst_pld),
        .rd     (rd),
        .rs1    (rs1),
        .rs2    (rs2),
        .rd_en  (rd_en),
        .rs1_en (rs1_en),
        .rs2_en (rs2_en)
    );

    imm_gen u_imm_gen (
        .inst (fetched_inst_pld),
        .imm  (imm)
    );

    unit_router u_unit_router (
        .inst        (fetched_inst_pld),
        .goto_alu    (sel_alu),
        .goto_lsu    (sel_lsu),
        .goto_mext   (sel_mext),
        .goto_csr    (sel_csr),
        .goto_spu    (sel_spu),
        .goto_custom (sel_custom),
        .goto_err    (sel_err)
    );

    // ========================================================================
    // register lock check and output stage
    // ========================================================================

    hazard_gate u_hazard_gate (
        .in_vld        (fetched_inst_vld),
        .in_rdy        (fetched_inst_rdy),
        .out_vld       (gated_vld),
        .out_rdy       (reg_rdy),
        .register_lock (register_lock),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .rd_en         (rd_en),
        .rs1_en        (rs1_en),
        .rs2_en        (rs2_en)
    );

    dec_out_reg u_dec_out_reg (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_vld         (gated_vld),
        .in_rdy         (reg_rdy),
        .inst           (fetched_inst_pld),
        .pc             (fetched_inst_pc),
        .id             (fetched_inst_id),
        .rd             (rd),
        .rd_en          (rd_en),
        .rs1            (rs1),
        .rs2            (rs2),
        .imm            (imm),
        .sel_alu        (sel_alu),
        .sel_lsu        (sel_lsu),
        .sel_mext       (sel_mext),
        .sel_csr        (sel_csr),
        .sel_spu        (sel_spu),
        .sel_custom     (sel_custom),
        .sel_err        (sel_err),
        .dec_inst_vld   (dec_inst_vld),
        .dec_inst_rdy   (dec_inst_rdy),
        .dec_inst_pld   (dec_inst_pld),
        .dec_inst_pc    (dec_inst_pc),
        .dec_inst_id    (dec_inst_id),
        .dec_inst_rd    (dec_inst_rd),
        .dec_inst_rd_en (dec_inst_rd_en),
        .dec_inst_rs1   (dec_inst_rs1),
        .dec_inst_rs2   (dec_inst_rs2),
        .dec_inst_imm   (dec_inst_imm),
        .goto_alu       (goto_alu),
        .goto_lsu       (goto_lsu),
        .goto_mext      (goto_mext),
        .goto_csr       (goto_csr),
        .goto_spu       (goto_spu),
        .goto_custom    (goto_custom),
        .goto_err       (goto_err)
    );

endmodule

`default_nettype wire

/* design/dec_out_reg.sv */
// one-entry valid/ready register holding the decoded instruction for the execute stage
`default_nettype none

module dec_out_reg (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 in_vld,
    output logic                 in_rdy,
    input  decode_pkg::inst_t    inst,
    input  decode_pkg::pc_t      pc,
    input  decode_pkg::inst_id_t id,
    input  decode_pkg::reg_idx_t rd,
    input  logic                 rd_en,
    input  decode_pkg::reg_idx_t rs1,
    input  decode_pkg::reg_idx_t rs2,
    input  decode_pkg::imm_t     imm,
    input  logic                 sel_alu,
    input  logic                 sel_lsu,
    input  logic                 sel_mext,
    input  logic                 sel_csr,
    input  logic                 sel_spu,
    input  logic                 sel_custom,
    input  logic                 sel_err,

    output logic                 dec_inst_vld,
    input  logic                 dec_inst_rdy,
    output decode_pkg::inst_t    dec_inst_pld,
    output decode_pkg::pc_t      dec_inst_pc,
    output decode_pkg::inst_id_t dec_inst_id,
    output decode_pkg::reg_idx_t dec_inst_rd,
    output logic                 dec_inst_rd_en,
    output decode_pkg::reg_idx_t dec_inst_rs1,
    output decode_pkg::reg_idx_t dec_inst_rs2,
    output decode_pkg::imm_t     dec_inst_imm,
    output logic                 goto_alu,
    output logic                 goto_lsu,
    output logic                 goto_mext,
    output logic                 goto_csr,
    output logic                 goto_spu,
    output logic                 goto_custom,
    output logic                 goto_err
);

    logic load;

    // empty, or the current entry leaves this cycle
    assign in_rdy = !dec_inst_vld | dec_inst_rdy;
    assign load   = in_vld & in_rdy;

    // ========================================================================
    // valid flag and unit selects
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_inst_vld <= 1'b0;
            goto_alu     <= 1'b0;
            goto_lsu     <= 1'b0;
            goto_mext    <= 1'b0;
            goto_csr     <= 1'b0;
            goto_spu     <= 1'b0;
            goto_custom  <= 1'b0;
            goto_err     <= 1'b0;
        end else if (load) begin
            dec_inst_vld <= 1'b1;
            goto_alu     <= sel_alu;
            goto_lsu     <= sel_lsu;
            goto_mext    <= sel_mext;
            goto_csr     <= sel_csr;
            goto_spu     <= sel_spu;
            goto_custom  <= sel_custom;
            goto_err     <= sel_err;
        end else if (dec_inst_rdy) begin
            // drained with nothing behind it
            dec_inst_vld <= 1'b0;
        end
    end

    // ========================================================================
    // payload
    // ========================================================================

    always_ff @(posedge clk) begin
        if (load) begin
            dec_inst_pld   <= inst;
            dec_inst_pc    <= pc;
            dec_inst_id    <= id;
            dec_inst_rd    <= rd;
            dec_inst_rd_en <= rd_en;
            dec_inst_rs1   <= rs1;
            dec_inst_rs2   <= rs2;
            dec_inst_imm   <= imm;
        end
    end

endmodule

`default_nettype wire

/* design/hazard_gate.sv */
// holds the fetch handshake while any register the instruction uses is locked
`default_nettype none

module hazard_gate (
    input  logic                  in_vld,
    output logic                  in_rdy,
    output logic                  out_vld,
    input  logic                  out_rdy,
    input  decode_pkg::reg_mask_t register_lock,
    input  decode_pkg::reg_idx_t  rd,
    input  decode_pkg::reg_idx_t  rs1,
    input  decode_pkg::reg_idx_t  rs2,
    input  logic                  rd_en,
    input  logic                  rs1_en,
    input  logic                  rs2_en
);

    logic rd_busy;
    logic rs1_busy;
    logic rs2_busy;
    logic pass;

    // a lock bit only matters for a register the instruction touches
    assign rd_busy  = rd_en  & register_lock[rd];
    assign rs1_busy = rs1_en & register_lock[rs1];
    assign rs2_busy = rs2_en & register_lock[rs2];

    assign pass = !(rd_busy | rs1_busy | rs2_busy);

    assign out_vld = in_vld  & pass;
    assign in_rdy  = out_rdy & pass;

endmodule

`default_nettype wire

/* design/unit_router.sv */
// picks exactly one execution unit for the instruction from opcode and function fields
`default_nettype none

module unit_router (
    input  decode_pkg::inst_t inst,
    output logic              goto_alu,
    output logic              goto_lsu,
    output logic              goto_mext,
    output logic              goto_csr,
    output logic              goto_spu,
    output logic              goto_custom,
    output logic              goto_err
);

    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t funct3;
    logic                funct7_b0;

    assign opcode    = inst[6:2];
    assign funct3    = inst[14:12];
    // m extension sets funct7 to 0000001
    assign funct7_b0 = inst[25];

    always_comb begin
        goto_alu    = 1'b0;
        goto_lsu    = 1'b0;
        goto_mext   = 1'b0;
        goto_csr    = 1'b0;
        goto_spu    = 1'b0;
        goto_custom = 1'b0;
        goto_err    = 1'b0;
        if (inst[1:0] != decode_pkg::QUAD_RV32) begin
            // compressed words are not supported here
            goto_err = 1'b1;
        end else begin
            case (opcode)
                decode_pkg::OPC_LUI,
                decode_pkg::OPC_AUIPC,
                decode_pkg::OPC_JAL,
                decode_pkg::OPC_JALR,
                decode_pkg::OPC_OP_IMM,
                decode_pkg::OPC_BRANCH,
                decode_pkg::OPC_MISC_MEM: goto_alu = 1'b1;
                decode_pkg::OPC_OP: begin
                    goto_mext = funct7_b0;
                    goto_alu  = !funct7_b0;
                end
                decode_pkg::OPC_LOAD,
                decode_pkg::OPC_STORE,
                decode_pkg::OPC_AMO:      goto_lsu = 1'b1;
                decode_pkg::OPC_SYSTEM: begin
                    goto_spu = (funct3 == decode_pkg::F3_PRIV);
                    goto_csr = (funct3 != decode_pkg::F3_PRIV);
                end
                decode_pkg::OPC_CUST0,
                decode_pkg::OPC_CUST1,
                decode_pkg::OPC_CUST2,
                decode_pkg::OPC_CUST3:    goto_custom = 1'b1;
                default:                  goto_err = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/imm_gen.sv */
// builds the 32-bit immediate of an rv32 instruction from its format
`default_nettype none

module imm_gen (
    input  decode_pkg::inst_t inst,
    output decode_pkg::imm_t  imm
);

    decode_pkg::opcode_t opcode;
    decode_pkg::imm_t    imm_i;
    decode_pkg::imm_t    imm_s;
    decode_pkg::imm_t    imm_b;
    decode_pkg::imm_t    imm_u;
    decode_pkg::imm_t    imm_j;

    assign opcode = inst[6:2];

    // ========================================================================
    // per-format immediates, all but u sign-extended from bit 31
    // ========================================================================

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    // ========================================================================
    // format select
    // ========================================================================

    always_comb begin
        case (opcode)
            decode_pkg::OPC_LUI:    imm = imm_u;
            decode_pkg::OPC_AUIPC:  imm = imm_u;
            decode_pkg::OPC_JAL:    imm = imm_j;
            decode_pkg::OPC_BRANCH: imm = imm_b;
            decode_pkg::OPC_STORE:  imm = imm_s;
            // amo addresses come straight from rs1
            decode_pkg::OPC_AMO:    imm = '0;
            // jalr, load, op-imm, system and the rest
            default:                imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

/* design/operand_decode.sv */
// extracts rd, rs1 and rs2 and flags which of them the instruction really uses
`default_nettype none

module operand_decode (
    input  decode_pkg::inst_t    inst,
    output decode_pkg::reg_idx_t rd,
    output decode_pkg::reg_idx_t rs1,
    output decode_pkg::reg_idx_t rs2,
    output logic                 rd_en,
    output logic                 rs1_en,
    output logic                 rs2_en
);

    decode_pkg::opcode_t opcode;
    decode_pkg::funct3_t funct3;
    logic                is_rv32;

    assign opcode  = inst[6:2];
    assign funct3  = inst[14:12];
    assign is_rv32 = (inst[1:0] == decode_pkg::QUAD_RV32);

    // fixed field positions for every rv32 format
    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    // destination write
    always_comb begin
        case (opcode)
            decode_pkg::OPC_BRANCH: rd_en = 1'b0;
            decode_pkg::OPC_STORE:  rd_en = 1'b0;
            // ecall/ebreak/mret write nothing, csr ops do
            decode_pkg::OPC_SYSTEM: rd_en = (funct3 != 3'b000);
            default:                rd_en = 1'b1;
        endcase
        if (!is_rv32) begin
            rd_en = 1'b0;
        end
    end

    // first source
    always_comb begin
        case (opcode)
            decode_pkg::OPC_LUI:   rs1_en = 1'b0;
            decode_pkg::OPC_AUIPC: rs1_en = 1'b0;
            decode_pkg::OPC_JAL:   rs1_en = 1'b0;
            default:               rs1_en = 1'b1;
        endcase
        if (!is_rv32) begin
            rs1_en = 1'b0;
        end
    end

    // second source, only r-type, s-type, b-type and amo
    always_comb begin
        case (opcode)
            decode_pkg::OPC_LUI:    rs2_en = 1'b0;
            decode_pkg::OPC_AUIPC:  rs2_en = 1'b0;
            decode_pkg::OPC_JAL:    rs2_en = 1'b0;
            decode_pkg::OPC_JALR:   rs2_en = 1'b0;
            decode_pkg::OPC_LOAD:   rs2_en = 1'b0;
            decode_pkg::OPC_OP_IMM: rs2_en = 1'b0;
            decode_pkg::OPC_SYSTEM: rs2_en = 1'b0;
            default:                rs2_en = 1'b1;
        endcase
        if (!is_rv32) begin
            rs2_en = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/decode_pkg.sv */
// shared widths, opcode constants and vector types for the instruction decode stage
`default_nettype none

package decode_pkg;

    // ========================================================================
    // widths
    // ========================================================================

    localparam int INST_ID_WIDTH = 4;

    typedef logic [31:0]              inst_t;
    typedef logic [31:0]              pc_t;
    typedef logic [INST_ID_WIDTH-1:0] inst_id_t;
    typedef logic [4:0]               reg_idx_t;
    typedef logic [31:0]              reg_mask_t;
    typedef logic [31:0]              imm_t;
    typedef logic [4:0]               opcode_t;
    typedef logic [2:0]               funct3_t;

    // ========================================================================
    // major opcodes, instruction bits 6..2
    // ========================================================================

    localparam opcode_t OPC_LOAD     = 5'b00000;
    localparam opcode_t OPC_MISC_MEM = 5'b00011;
    localparam opcode_t OPC_OP_IMM   = 5'b00100;
    localparam opcode_t OPC_AUIPC    = 5'b00101;
    localparam opcode_t OPC_STORE    = 5'b01000;
    localparam opcode_t OPC_AMO      = 5'b01011;
    localparam opcode_t OPC_OP       = 5'b01100;
    localparam opcode_t OPC_LUI      = 5'b01101;
    localparam opcode_t OPC_BRANCH   = 5'b11000;
    localparam opcode_t OPC_JALR     = 5'b11001;
    localparam opcode_t OPC_JAL      = 5'b11011;
    localparam opcode_t OPC_SYSTEM   = 5'b11100;

    // custom-0..3 slots reserved by the ISA
    localparam opcode_t OPC_CUST0    = 5'b00010;
    localparam opcode_t OPC_CUST1    = 5'b01010;
    localparam opcode_t OPC_CUST2    = 5'b10110;
    localparam opcode_t OPC_CUST3    = 5'b11110;

    // ========================================================================
    // function fields and length marker
    // ========================================================================

    // ecall, ebreak, mret, wfi share funct3 0
    localparam funct3_t F3_PRIV = 3'b000;

    // low two bits of a full 32-bit instruction
    localparam logic [1:0] QUAD_RV32 = 2'b11;

endpackage

`default_nettype wire
